// File: source/routerPkg.sv
package routerPkg;

  // Input sides of the router, in rotation order
  localparam int portCount = 5;

  localparam int portLocal = 0;
  localparam int portNorth = 1;
  localparam int portEast  = 2;
  localparam int portWest  = 3;
  localparam int portSouth = 4;

  // Flit layout is id in the top bits, payload below
  localparam int flitIdWidth = 3;
  localparam int lengthWidth = 12;
  localparam int flitWidth   = 16;

  typedef logic [flitWidth-1:0]   flitWord;
  typedef logic [flitIdWidth-1:0] flitId;
  typedef logic [lengthWidth-1:0] pktLength;
  typedef logic [portCount-1:0]   portMask;

  // A header flit carries the packet length in its low payload bits
  localparam flitId flitHeaderId = 3'd1;

  typedef enum logic [2:0]
  {
    ownIdle,
    ownLocal,
    ownNorth,
    ownEast,
    ownWest,
    ownSouth
  } ownerState;

endpackage

// File: source/flitBudgetCounter.sv
`timescale 1ns/100ps

module flitBudgetCounter
  import routerPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  flitWord flit,
  input  logic    forward,
  output logic    done
);

  pktLength limit;
  pktLength count;
  flitId    id;

  assign id = flit[flitWidth-1 -: flitIdWidth];

  // The header itself is the first flit of the packet, so the count restarts at one
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else if (forward)
    begin
      if (id == flitHeaderId)
      begin
        limit <= flit[lengthWidth-1:0];
        count <= pktLength'(1);
      end
      else
      begin
        count <= count + pktLength'(1);
      end
    end
  end

  // Equal counts also hold after reset, so an unused side reads as done
  assign done = (count == limit);

endmodule

// File: source/inputPort.sv
`timescale 1ns/100ps

module inputPort
  import routerPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    inReq,
  input  flitWord inFlit,
  output logic    inAck,
  input  logic    forward,
  output logic    held,
  output flitWord flit
);

  typedef enum logic
  {
    recvIdle,
    recvAck
  } recvState;

  recvState state;
  logic     accept;

  // A new flit is only taken while the one-flit register is free
  assign accept = (state == recvIdle) && inReq && !held;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= recvIdle;
    end
    else
    begin
      case (state)
        recvIdle:
          if (accept)
            state <= recvAck;
        recvAck:
          if (!inReq)
            state <= recvIdle;
        default:
          state <= recvIdle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      held <= 1'b0;
    else if (forward)
      held <= 1'b0;
    else if (accept)
      held <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      flit <= inFlit;
  end

  assign inAck = (state == recvAck);

endmodule

// File: source/outputArbiter.sv
`timescale 1ns/100ps

module outputArbiter
  import routerPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  portMask held,
  input  flitWord flitL,
  input  flitWord flitN,
  input  flitWord flitE,
  input  flitWord flitW,
  input  flitWord flitS,
  input  portMask forward,
  output portMask grant
);

  ownerState  state;
  ownerState  nextState;
  logic [2:0] ownerIdx;
  logic       started;
  logic       ownerDone;
  logic       ownerForward;
  logic       rotate;
  portMask    done;

  flitBudgetCounter i_budgetL (
    .clk     (clk),
    .rst     (rst),
    .flit    (flitL),
    .forward (forward[portLocal]),
    .done    (done[portLocal])
  );

  flitBudgetCounter i_budgetN (
    .clk     (clk),
    .rst     (rst),
    .flit    (flitN),
    .forward (forward[portNorth]),
    .done    (done[portNorth])
  );

  flitBudgetCounter i_budgetE (
    .clk     (clk),
    .rst     (rst),
    .flit    (flitE),
    .forward (forward[portEast]),
    .done    (done[portEast])
  );

  flitBudgetCounter i_budgetW (
    .clk     (clk),
    .rst     (rst),
    .flit    (flitW),
    .forward (forward[portWest]),
    .done    (done[portWest])
  );

  flitBudgetCounter i_budgetS (
    .clk     (clk),
    .rst     (rst),
    .flit    (flitS),
    .forward (forward[portSouth]),
    .done    (done[portSouth])
  );

  assign ownerIdx = 3'(state - 1);

  always_comb
  begin
    grant = '0;
    if (state != ownIdle)
      grant[ownerIdx] = 1'b1;
  end

  assign ownerDone    = |(grant & done);
  assign ownerForward = |(grant & forward);

  // The counter still shows the previous packet as done until the new header
  // has been forwarded, so the owner is only released after it has started
  assign rotate = (state != ownIdle) && started && ownerDone;

  always_comb
  begin
    int side;
    side      = 0;
    nextState = state;
    if (state == ownIdle)
    begin
      for (int i = portCount - 1; i >= 0; i--)
      begin
        if (held[i])
          nextState = ownerState'(3'(i + 1));
      end
    end
    else if (rotate)
    begin
      // Search from the side after the owner, owner last
      nextState = ownIdle;
      for (int i = portCount; i >= 1; i--)
      begin
        side = (int'(ownerIdx) + i) % portCount;
        if (held[side])
          nextState = ownerState'(3'(side + 1));
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state   <= ownIdle;
      started <= 1'b0;
    end
    else
    begin
      state <= nextState;
      if (rotate)
        started <= 1'b0;
      else if (ownerForward)
        started <= 1'b1;
    end
  end

endmodule

// File: source/outputStage.sv
`timescale 1ns/100ps

module outputStage
  import routerPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  portMask grant,
  input  portMask held,
  input  flitWord flitL,
  input  flitWord flitN,
  input  flitWord flitE,
  input  flitWord flitW,
  input  flitWord flitS,
  output portMask forward,
  output logic    outReq,
  input  logic    outAck,
  output flitWord outFlit
);

  typedef enum logic [1:0]
  {
    sendEmpty,
    sendReq,
    sendWaitLow
  } sendState;

  sendState state;
  flitWord  ownerFlit;

  // Grant is one-hot, so at most one side can be selected here
  always_comb
  begin
    ownerFlit = '0;
    if (grant[portLocal])
      ownerFlit = flitL;
    if (grant[portNorth])
      ownerFlit = flitN;
    if (grant[portEast])
      ownerFlit = flitE;
    if (grant[portWest])
      ownerFlit = flitW;
    if (grant[portSouth])
      ownerFlit = flitS;
  end

  assign forward = (state == sendEmpty) ? (grant & held) : '0;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= sendEmpty;
    end
    else
    begin
      case (state)
        sendEmpty:
          if (|forward)
            state <= sendReq;
        sendReq:
          if (outAck)
            state <= sendWaitLow;
        sendWaitLow:
          if (!outAck)
            state <= sendEmpty;
        default:
          state <= sendEmpty;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (|forward)
      outFlit <= ownerFlit;
  end

  assign outReq = (state == sendReq);

endmodule

// File: source/routerOutputTop.sv
`timescale 1ns/100ps

module routerOutputTop
  import routerPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  portMask inReq,
  output portMask inAck,
  input  flitWord inFlitL,
  input  flitWord inFlitN,
  input  flitWord inFlitE,
  input  flitWord inFlitW,
  input  flitWord inFlitS,
  output logic    outReq,
  input  logic    outAck,
  output flitWord outFlit
);

  portMask held;
  portMask forward;
  portMask grant;
  flitWord flitL;
  flitWord flitN;
  flitWord flitE;
  flitWord flitW;
  flitWord flitS;

  inputPort i_inputPortL (
    .clk     (clk),
    .rst     (rst),
    .inReq   (inReq[portLocal]),
    .inFlit  (inFlitL),
    .inAck   (inAck[portLocal]),
    .forward (forward[portLocal]),
    .held    (held[portLocal]),
    .flit    (flitL)
  );

  inputPort i_inputPortN (
    .clk     (clk),
    .rst     (rst),
    .inReq   (inReq[portNorth]),
    .inFlit  (inFlitN),
    .inAck   (inAck[portNorth]),
    .forward (forward[portNorth]),
    .held    (held[portNorth]),
    .flit    (flitN)
  );

  inputPort i_inputPortE (
    .clk     (clk),
    .rst     (rst),
    .inReq   (inReq[portEast]),
    .inFlit  (inFlitE),
    .inAck   (inAck[portEast]),
    .forward (forward[portEast]),
    .held    (held[portEast]),
    .flit    (flitE)
  );

  inputPort i_inputPortW (
    .clk     (clk),
    .rst     (rst),
    .inReq   (inReq[portWest]),
    .inFlit  (inFlitW),
    .inAck   (inAck[portWest]),
    .forward (forward[portWest]),
    .held    (held[portWest]),
    .flit    (flitW)
  );

  inputPort i_inputPortS (
    .clk     (clk),
    .rst     (rst),
    .inReq   (inReq[portSouth]),
    .inFlit  (inFlitS),
    .inAck   (inAck[portSouth]),
    .forward (forward[portSouth]),
    .held    (held[portSouth]),
    .flit    (flitS)
  );

  outputArbiter i_outputArbiter (
    .clk     (clk),
    .rst     (rst),
    .held    (held),
    .flitL   (flitL),
    .flitN   (flitN),
    .flitE   (flitE),
    .flitW   (flitW),
    .flitS   (flitS),
    .forward (forward),
    .grant   (grant)
  );

  outputStage i_outputStage (
    .clk     (clk),
    .rst     (rst),
    .grant   (grant),
    .held    (held),
    .flitL   (flitL),
    .flitN   (flitN),
    .flitE   (flitE),
    .flitW   (flitW),
    .flitS   (flitS),
    .forward (forward),
    .outReq  (outReq),
    .outAck  (outAck),
    .outFlit (outFlit)
  );

endmodule

// File: tb/routerOutputAssert.sv
`timescale 1ns/100ps

module routerOutputAssert
  import routerPkg::*;
(
  input logic    clk,
  input logic    rst,
  input portMask inReq,
  input portMask inAck,
  input logic    outReq,
  input logic    outAck,
  input flitWord outFlit,
  input portMask grant
);

  logic resetFail   = 1'b0;
  logic ackRiseFail = 1'b0;
  logic ackHoldFail = 1'b0;
  logic reqHoldFail = 1'b0;
  logic flitFail    = 1'b0;
  logic reqRiseFail = 1'b0;
  logic anyFailed;

  assign anyFailed = resetFail | ackRiseFail | ackHoldFail | reqHoldFail |
                     flitFail | reqRiseFail;

  // One cycle into reset every handshake output and the grant are low
  assert property (@(posedge clk) rst |=> (inAck == '0 && !outReq && grant == '0))
  else
  begin
    $error("Handshake outputs or grant not idle during reset");
    resetFail = 1'b1;
  end

  // inAck may only rise for a request that was seen on the previous edge
  assert property (@(posedge clk) disable iff (rst)
    ((inAck & ~$past(inAck)) & ~$past(inReq)) == '0)
  else
  begin
    $error("inAck rose without a request");
    ackRiseFail = 1'b1;
  end

  assert property (@(posedge clk) disable iff (rst) ($past(inAck & inReq) & ~inAck) == '0)
  else
  begin
    $error("inAck fell while inReq was still high");
    ackHoldFail = 1'b1;
  end

  assert property (@(posedge clk) disable iff (rst) outReq && !outAck |=> outReq)
  else
  begin
    $error("outReq fell before outAck was high");
    reqHoldFail = 1'b1;
  end

  assert property (@(posedge clk) disable iff (rst) outReq && !outAck |=> $stable(outFlit))
  else
  begin
    $error("outFlit changed while waiting for outAck");
    flitFail = 1'b1;
  end

  // A new output transfer only starts once the sink has dropped outAck
  assert property (@(posedge clk) disable iff (rst) $rose(outReq) |-> !$past(outAck))
  else
  begin
    $error("outReq rose while outAck was still high");
    reqRiseFail = 1'b1;
  end

endmodule

bind routerOutputTop routerOutputAssert i_routerOutputAssert (
  .clk     (clk),
  .rst     (rst),
  .inReq   (inReq),
  .inAck   (inAck),
  .outReq  (outReq),
  .outAck  (outAck),
  .outFlit (outFlit),
  .grant   (grant)
);

// File: tb/routerOutputTb.sv
`timescale 1ns/100ps

module routerOutputTb
  import routerPkg::*;
();

  localparam int packetsPerSource = 6;
  localparam int maxPacketLength  = 6;
  localparam flitId flitBodyId    = 3'd2;
  localparam flitId flitTailId    = 3'd3;

  logic    clk = 1'b0;
  logic    rst;
  portMask inReq;
  portMask inAck;
  flitWord inFlit [portCount];
  logic    outReq;
  logic    outAck;
  flitWord outFlit;

  // Flits handed to the DUT, per source and in order
  flitWord expected [portCount][$];
  int      packetLength [portCount][packetsPerSource];
  int      cycleCount = 0;
  int      timeoutCycles = 0;

  // Sides whose flit was acked but has not left yet, as seen from the handshakes
  portMask waiting;
  portMask lastInAck;
  logic    lastOutReq;
  int      nextOwner;
  int      flitsLeft;
  logic    assertFailed;

  routerOutputTop i_routerOutputTop (
    .clk     (clk),
    .rst     (rst),
    .inReq   (inReq),
    .inAck   (inAck),
    .inFlitL (inFlit[portLocal]),
    .inFlitN (inFlit[portNorth]),
    .inFlitE (inFlit[portEast]),
    .inFlitW (inFlit[portWest]),
    .inFlitS (inFlit[portSouth]),
    .outReq  (outReq),
    .outAck  (outAck),
    .outFlit (outFlit)
  );

  assign assertFailed = i_routerOutputTop.i_routerOutputAssert.anyFailed;

  always #2 clk = ~clk;

  task automatic reportFailure(string line);
    $display("%s", line);
    $display("Test failures found");
    $fatal(1, "Simulation stopped after a failed check");
  endtask

  always @(posedge clk)
  begin
    cycleCount = cycleCount + 1;
    if (cycleCount > timeoutCycles)
      reportFailure($sformatf("Timeout: not all flits arrived within %0d cycles", timeoutCycles));
  end

  always @(negedge clk)
  begin
    if (assertFailed)
      reportFailure("A protocol assertion on the DUT failed");
  end

  function automatic logic allDelivered();
    logic empty;
    empty = 1'b1;
    for (int s = 0; s < portCount; s++)
      if (expected[s].size() != 0)
        empty = 1'b0;
    return empty;
  endfunction

  task automatic checkOutputFlit(flitWord got);
    flitWord want;
    int      owner;
    int      side;
    owner = nextOwner;
    assert (owner >= 0)
    else reportFailure("An output flit appeared while no source was waiting");
    assert (expected[owner].size() > 0)
    else reportFailure($sformatf("Source %0d had no flit left but the output took one", owner));
    want = expected[owner].pop_front();
    assert (got == want)
    else
      reportFailure($sformatf("** Error at %0t: outFlit = 0x%04h, expected 0x%04h (source %0d)",
                              $time, got, want, owner));
    waiting[owner] = 1'b0;
    if (flitsLeft == 0)
      flitsLeft = int'(want[lengthWidth-1:0]) - 1;
    else
      flitsLeft = flitsLeft - 1;
    // After the last flit the next owner is the first waiting side after this one
    if (flitsLeft == 0)
    begin
      nextOwner = -1;
      for (int i = 1; i <= portCount; i++)
      begin
        side = (owner + i) % portCount;
        if (nextOwner < 0 && waiting[side])
          nextOwner = side;
      end
    end
  endtask

  // Scoreboard samples mid-cycle, where both DUT outputs and driven inputs are settled
  always @(negedge clk)
  begin
    if (rst)
    begin
      waiting    = '0;
      lastInAck  = '0;
      lastOutReq = 1'b0;
      nextOwner  = -1;
      flitsLeft  = 0;
    end
    else
    begin
      waiting = waiting | (inAck & ~lastInAck);
      if (outReq && !lastOutReq)
        checkOutputFlit(outFlit);
      // Idle output goes to the lowest waiting side
      if (nextOwner < 0)
      begin
        for (int i = portCount - 1; i >= 0; i--)
          if (waiting[i])
            nextOwner = i;
      end
      lastInAck  = inAck;
      lastOutReq = outReq;
    end
  end

  task automatic waitAck(int src, logic level);
    do
    begin
      @(posedge clk);
      #1;
    end
    while (inAck[src] != level);
  endtask

  task automatic sendFlit(int src, flitWord f);
    expected[src].push_back(f);
    @(posedge clk);
    #1;
    inFlit[src] = f;
    inReq[src]  = 1'b1;
    waitAck(src, 1'b1);
    inReq[src] = 1'b0;
    waitAck(src, 1'b0);
  endtask

  // Headers carry only the length, body and tail flits carry source and sequence
  task automatic runSource(int src);
    flitWord f;
    int      seq;
    int      len;
    int      gap;
    seq = 0;
    for (int p = 0; p < packetsPerSource; p++)
    begin
      len = packetLength[src][p];
      for (int k = 0; k < len; k++)
      begin
        if (k == 0)
          f = {flitHeaderId, 1'b0, pktLength'(len)};
        else if (k == len - 1)
          f = {flitTailId, 3'(src), 10'(seq)};
        else
          f = {flitBodyId, 3'(src), 10'(seq)};
        seq = seq + 1;
        gap = $urandom_range(0, 3);
        repeat (gap) @(posedge clk);
        sendFlit(src, f);
      end
    end
  endtask

  task automatic runSink();
    int delay;
    forever
    begin
      @(posedge clk);
      #1;
      if (outReq)
      begin
        delay = $urandom_range(0, 5);
        repeat (delay)
        begin
          @(posedge clk);
          #1;
        end
        outAck = 1'b1;
        while (outReq)
        begin
          @(posedge clk);
          #1;
        end
        // A slow sink may keep outAck high for a while after outReq falls
        delay = $urandom_range(0, 2);
        repeat (delay)
        begin
          @(posedge clk);
          #1;
        end
        outAck = 1'b0;
      end
    end
  endtask

  initial
  begin
    int totalFlits;
    void'($urandom(32'hd3be85f5));
    rst    = 1'b1;
    inReq  = '0;
    outAck = 1'b0;
    for (int s = 0; s < portCount; s++)
      inFlit[s] = '0;
    totalFlits = 0;
    for (int s = 0; s < portCount; s++)
    begin
      for (int p = 0; p < packetsPerSource; p++)
      begin
        packetLength[s][p] = $urandom_range(1, maxPacketLength);
        totalFlits = totalFlits + packetLength[s][p];
      end
    end
    timeoutCycles = totalFlits * 20 + 200;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (2)
    begin
      @(negedge clk);
      assert (inAck == '0 && !outReq && i_routerOutputTop.grant == '0)
      else reportFailure("Handshake outputs or grant were active after reset with no request");
    end
    fork
      runSink();
    join_none
    fork
      runSource(portLocal);
      runSource(portNorth);
      runSource(portEast);
      runSource(portWest);
      runSource(portSouth);
    join
    while (!allDelivered())
      @(posedge clk);
    repeat (10) @(posedge clk);
    assert (flitsLeft == 0 && waiting == '0)
    else reportFailure("A packet was left unfinished at the end of the run");
    if (assertFailed)
      reportFailure("A protocol assertion on the DUT failed");
    else
    begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

// File: files.f
source/routerPkg.sv
source/flitBudgetCounter.sv
source/inputPort.sv
source/outputArbiter.sv
source/outputStage.sv
source/routerOutputTop.sv
tb/routerOutputAssert.sv
tb/routerOutputTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the router output testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module routerOutputTb -Mdir obj_dir -o routerOutputSim -f files.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Keep running after an assertion error so the testbench can report it
./obj_dir/routerOutputSim +verilator+error+limit+1000 > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
fi

if grep -q 'All tests passed!' "$logFile"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
